// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = cp0Tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/cp0AccessDecode.sv ====
// Combinational decode of one exception or one register write per cycle.
// A valid exception always wins; a write in the same cycle is dropped.
// Unknown exception kinds produce no action.
`default_nettype none
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0AccessDecode
    import cp0Pkg::*;
(
    input  regAccess_t access_i,
    input  excReq_t    exc_i,
    output cp0Cmd_t    cmd_o
);

    always_comb begin
        cmd_o       = '0;
        cmd_o.wdata = access_i.wdata;

        if (exc_i.valid) begin
            // ERET is the only kind that leaves exception level
            cmd_o.enterExc = exc_i.kind inside {excInt, excAdel, excAdes, excSys, excBp,
                                                excRi, excCpu, excOv, excTr};
            cmd_o.leaveExc    = (exc_i.kind == excEret);
            cmd_o.loadBadAddr = exc_i.kind inside {excAdel, excAdes};
            cmd_o.loadCe      = (exc_i.kind == excCpu);

            case (exc_i.kind)
                excInt:  cmd_o.excCode = `CP0_EXC_INT;
                excAdel: cmd_o.excCode = `CP0_EXC_ADEL;
                excAdes: cmd_o.excCode = `CP0_EXC_ADES;
                excSys:  cmd_o.excCode = `CP0_EXC_SYS;
                excBp:   cmd_o.excCode = `CP0_EXC_BP;
                excRi:   cmd_o.excCode = `CP0_EXC_RI;
                excCpu:  cmd_o.excCode = `CP0_EXC_CPU;
                excOv:   cmd_o.excCode = `CP0_EXC_OV;
                excTr:   cmd_o.excCode = `CP0_EXC_TR;
                default: cmd_o.excCode = 5'd0;
            endcase
        end else if (access_i.wen) begin
            // Writes to read-only or absent registers are ignored
            case (access_i.addr)
                `CP0_REG_STATUS:   cmd_o.wrStatus   = 1'b1;
                `CP0_REG_CAUSE:    cmd_o.wrCause    = 1'b1;
                `CP0_REG_EPC:      cmd_o.wrEpc      = 1'b1;
                `CP0_REG_BADVADDR: cmd_o.wrBadVAddr = 1'b1;
                `CP0_REG_COUNT:    cmd_o.wrCount    = 1'b1;
                `CP0_REG_COMPARE:  cmd_o.wrCompare  = 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Register blocks rely on at most one write target per cycle
    always_comb begin
        assert ($onehot0({cmd_o.wrStatus, cmd_o.wrCause, cmd_o.wrEpc,
                          cmd_o.wrBadVAddr, cmd_o.wrCount, cmd_o.wrCompare}))
        else $error("cp0AccessDecode: more than one write strobe active");
    end

endmodule

`default_nettype wire

// ==== logic/cp0ExcState.sv ====
// Status, Cause, EPC and BadVAddr with exception entry and return.
// EPC and Cause.BD are frozen while EXL is set, so nested exceptions keep the first PC.
// Cause.IP[7:2] samples the hardware interrupt lines every cycle.
`default_nettype none
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0ExcState
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cp0Cmd_t     cmd_i,
    input  excReq_t     exc_i,
    input  logic [5:0]  intr_i,
    output statusReg_t  status_o,
    output causeReg_t   cause_o,
    output logic [31:0] epc_o,
    output logic [31:0] badVAddr_o,
    output logic        usermode_o
);

    statusReg_t  statusQ;
    causeReg_t   causeQ;
    logic [31:0] epcQ;
    logic [31:0] badVAddrQ;

    statusReg_t  wrStatus;
    causeReg_t   wrCause;
    logic [31:0] pcMinus4;

    // Write data viewed through the register layouts
    assign wrStatus = statusReg_t'(cmd_i.wdata);
    assign wrCause  = causeReg_t'(cmd_i.wdata);

    // Branch delay slot reports the branch itself
    assign pcMinus4 = exc_i.pc - 32'd4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusQ   <= statusReg_t'(`CP0_STATUS_RESET);
            causeQ    <= '0;
            epcQ      <= '0;
            badVAddrQ <= '0;
        end else begin
            causeQ.ip[7:2] <= intr_i;

            if (cmd_i.enterExc) begin
                if (!statusQ.exl) begin
                    epcQ      <= exc_i.inSlot ? pcMinus4 : exc_i.pc;
                    causeQ.bd <= exc_i.inSlot;
                end
                statusQ.exl    <= 1'b1;
                causeQ.excCode <= cmd_i.excCode;
                if (cmd_i.loadCe) begin
                    causeQ.ce <= exc_i.cpNum;
                end
                if (cmd_i.loadBadAddr) begin
                    badVAddrQ <= exc_i.badAddr;
                end
            end else if (cmd_i.leaveExc) begin
                statusQ.exl <= 1'b0;
            end else begin
                if (cmd_i.wrStatus) begin
                    statusQ.cu0 <= wrStatus.cu0;
                    statusQ.bev <= wrStatus.bev;
                    statusQ.im  <= wrStatus.im;
                    statusQ.um  <= wrStatus.um;
                    statusQ.erl <= wrStatus.erl;
                    statusQ.exl <= wrStatus.exl;
                    statusQ.ie  <= wrStatus.ie;
                end
                // Only IV and the two software interrupt bits are writable
                if (cmd_i.wrCause) begin
                    causeQ.iv      <= wrCause.iv;
                    causeQ.ip[1:0] <= wrCause.ip[1:0];
                end
                if (cmd_i.wrEpc) begin
                    epcQ <= cmd_i.wdata;
                end
                if (cmd_i.wrBadVAddr) begin
                    badVAddrQ <= cmd_i.wdata;
                end
            end
        end
    end

    assign status_o   = statusQ;
    assign cause_o    = causeQ;
    assign epc_o      = epcQ;
    assign badVAddr_o = badVAddrQ;

    // Kernel mode whenever either exception level bit is set
    assign usermode_o = statusQ.um & ~(statusQ.erl | statusQ.exl);

    // Decode never asks for entry and return in the same cycle
    excEnterLeaveExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(cmd_i.enterExc && cmd_i.leaveExc)
    ) else $error("cp0ExcState: enterExc and leaveExc together");

endmodule

`default_nettype wire

// ==== logic/cp0Pkg.sv ====
// Types shared by the CP0 blocks.
// Status and Cause layouts follow the MIPS32 bit positions; reserved bits read zero.
`default_nettype none

package cp0Pkg;

    typedef enum logic [3:0] {
        excNone = 4'd0,
        excInt,
        excAdel,
        excAdes,
        excSys,
        excBp,
        excRi,
        excCpu,
        excOv,
        excTr,
        excEret
    } excType_e;

    // Exception report from the pipeline, one per cycle at most
    typedef struct packed {
        logic        valid;
        excType_e    kind;
        logic [31:0] pc;
        logic [31:0] badAddr;
        logic [1:0]  cpNum;
        logic        inSlot;
    } excReq_t;

    // MTC0/MFC0 port
    typedef struct packed {
        logic [4:0]  addr;
        logic        wen;
        logic [31:0] wdata;
    } regAccess_t;

    // Update command from decode to the register blocks
    typedef struct packed {
        logic        wrStatus;
        logic        wrCause;
        logic        wrEpc;
        logic        wrBadVAddr;
        logic        wrCount;
        logic        wrCompare;
        logic [31:0] wdata;
        logic        enterExc;
        logic        leaveExc;
        logic        loadBadAddr;
        logic        loadCe;
        logic [4:0]  excCode;
    } cp0Cmd_t;

    typedef struct packed {
        logic [2:0] rsvd31;
        logic       cu0;
        logic [4:0] rsvd27;
        logic       bev;
        logic [5:0] rsvd21;
        logic [7:0] im;
        logic [2:0] rsvd7;
        logic       um;
        logic       rsvd3;
        logic       erl;
        logic       exl;
        logic       ie;
    } statusReg_t;

    typedef struct packed {
        logic       bd;
        logic       rsvd30;
        logic [1:0] ce;
        logic [3:0] rsvd27;
        logic       iv;
        logic [6:0] rsvd22;
        logic [7:0] ip;
        logic       rsvd7;
        logic [4:0] excCode;
        logic [1:0] rsvd1;
    } causeReg_t;

endpackage

`default_nettype wire

// ==== logic/cp0ReadMux.sv ====
// Read port for MFC0, purely combinational.
// Register numbers without a register here read as zero.
`default_nettype none
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0ReadMux
    import cp0Pkg::*;
(
    input  logic [4:0]  addr_i,
    input  statusReg_t  status_i,
    input  causeReg_t   cause_i,
    input  logic [31:0] epc_i,
    input  logic [31:0] badVAddr_i,
    input  logic [31:0] count_i,
    input  logic [31:0] compare_i,
    output logic [31:0] rdata_o
);

    always_comb begin
        case (addr_i)
            `CP0_REG_BADVADDR: rdata_o = badVAddr_i;
            `CP0_REG_COUNT:    rdata_o = count_i;
            `CP0_REG_COMPARE:  rdata_o = compare_i;
            `CP0_REG_STATUS:   rdata_o = 32'(status_i);
            `CP0_REG_CAUSE:    rdata_o = 32'(cause_i);
            `CP0_REG_EPC:      rdata_o = epc_i;
            `CP0_REG_PRID:     rdata_o = `CP0_PRID_VALUE;
            default:           rdata_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cp0Timer.sv ====
// Count and Compare with the timer interrupt flag.
// Count increments every cycle; a Compare of zero never raises the flag.
// The flag holds until Compare is written again.
`default_nettype none
`timescale 1ns/1ps

module cp0Timer
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cp0Cmd_t     cmd_i,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timerInt_o
);

    logic [31:0] countQ;
    logic [31:0] compareQ;
    logic        timerIntQ;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countQ    <= '0;
            compareQ  <= '0;
            timerIntQ <= 1'b0;
        end else begin
            // Loaded value is visible at this edge and counts on from the next
            countQ <= cmd_i.wrCount ? cmd_i.wdata : countQ + 32'd1;

            if (cmd_i.wrCompare) begin
                compareQ  <= cmd_i.wdata;
                timerIntQ <= 1'b0;
            end else if (compareQ != 32'd0 && countQ == compareQ) begin
                timerIntQ <= 1'b1;
            end
        end
    end

    assign count_o    = countQ;
    assign compare_o  = compareQ;
    assign timerInt_o = timerIntQ;

    // Only a Compare write acknowledges the timer interrupt
    timerClearOnCompare: assert property (
        @(posedge clk) disable iff (rst)
        $fell(timerInt_o) |-> $past(cmd_i.wrCompare)
    ) else $error("cp0Timer: timer interrupt dropped without Compare write");

endmodule

`default_nettype wire

// ==== logic/cp0Top.sv ====
// Reduced MIPS32 CP0 with exceptions and the timer, no TLB.
// Reads are combinational; writes and exceptions take effect at the next edge.
// One exception or one write per cycle, with the exception taking priority.
`default_nettype none
`timescale 1ns/1ps

module cp0Top
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [5:0]  intr_i,
    input  regAccess_t  access_i,
    input  excReq_t     exc_i,
    output logic [31:0] rdata_o,
    output statusReg_t  status_o,
    output causeReg_t   cause_o,
    output logic [31:0] epc_o,
    output logic        usermode_o,
    output logic        timerInt_o
);

    cp0Cmd_t     cmd;
    logic [31:0] badVAddr;
    logic [31:0] count;
    logic [31:0] compare;

    cp0AccessDecode u_decode (
        .access_i (access_i),
        .exc_i    (exc_i),
        .cmd_o    (cmd)
    );

    cp0ExcState u_state (
        .clk        (clk),
        .rst        (rst),
        .cmd_i      (cmd),
        .exc_i      (exc_i),
        .intr_i     (intr_i),
        .status_o   (status_o),
        .cause_o    (cause_o),
        .epc_o      (epc_o),
        .badVAddr_o (badVAddr),
        .usermode_o (usermode_o)
    );

    cp0Timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .cmd_i      (cmd),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt_o)
    );

    // Read word follows the live register outputs
    cp0ReadMux u_read (
        .addr_i     (access_i.addr),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badVAddr_i (badVAddr),
        .count_i    (count),
        .compare_i  (compare),
        .rdata_o    (rdata_o)
    );

endmodule

`default_nettype wire

// ==== logic/cp0_macros.svh ====
// Register numbers, ExcCode values and reset words for the reduced CP0.
// Only the exception and timer registers have numbers here. The TLB side is absent.
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// CP0 register numbers, select 0 only
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15

// Fixed processor ID word
`define CP0_PRID_VALUE 32'h00004220

// Cause.ExcCode encodings
`define CP0_EXC_INT  5'd0
`define CP0_EXC_ADEL 5'd4
`define CP0_EXC_ADES 5'd5
`define CP0_EXC_SYS  5'd8
`define CP0_EXC_BP   5'd9
`define CP0_EXC_RI   5'd10
`define CP0_EXC_CPU  5'd11
`define CP0_EXC_OV   5'd12
`define CP0_EXC_TR   5'd13

// Status comes out of reset with BEV and ERL set
`define CP0_STATUS_RESET 32'h00400004

`endif

// ==== sim.f ====
+incdir+logic
logic/cp0Pkg.sv
logic/cp0AccessDecode.sv
logic/cp0ExcState.sv
logic/cp0Timer.sv
logic/cp0ReadMux.sv
logic/cp0Top.sv
verif/cp0Tb.sv

// ==== verif/cp0Tb.sv ====
// Self-checking testbench for cp0Top, driven against a cycle-level shadow model
// Inputs change on the falling edge and outputs are compared 2 ns later
// Random data comes from a Galois LFSR with a fixed seed, so every run is identical
`default_nettype none
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0Tb
    import cp0Pkg::*;
();

    localparam logic [31:0] LFSR_TAPS   = 32'h80200003;
    localparam logic [31:0] STATUS_MASK = 32'h1040FF17;
    localparam logic [31:0] CAUSE_MASK  = 32'h00800300;
    // Budgets for reset, writes, exceptions, BadVAddr, timer and interrupt tests
    localparam int TEST_CYCLES = 40 + 400 + 300 + 300 + 500 + 400;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [5:0]  intr = '0;
    regAccess_t  access = '0;
    excReq_t     excIn = '0;
    logic [31:0] rdata;
    statusReg_t  status;
    causeReg_t   cause;
    logic [31:0] epc;
    logic        usermode;
    logic        timerInt;

    logic [31:0] lfsr = 32'h50f32112;
    logic [31:0] shStatus, shCause, shEpc, shBad, shCount, shCompare;
    logic        shTimer;
    logic [31:0] expRead, expStatus, expCause, expEpc;
    logic        expUser, expTimer;
    logic        checkEn = 1'b0;
    logic [5:0]  intrNext = '0;
    string       testName = "reset";
    int          errCount = 0;
    int          errAtStart = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          cycles = 0;

    cp0Top dut (
        .clk        (clk),
        .rst        (rst),
        .intr_i     (intr),
        .access_i   (access),
        .exc_i      (excIn),
        .rdata_o    (rdata),
        .status_o   (status),
        .cause_o    (cause),
        .epc_o      (epc),
        .usermode_o (usermode),
        .timerInt_o (timerInt)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped: no result after %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        logic        outBit;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsr[0];
            lfsr   = lfsr >> 1;
            if (outBit) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            bits = {bits[30:0], outBit};
        end
        return bits;
    endfunction

    function automatic logic [4:0] excCodeOf(input excType_e kind);
        case (kind)
            excAdel: return `CP0_EXC_ADEL;
            excAdes: return `CP0_EXC_ADES;
            excSys:  return `CP0_EXC_SYS;
            excBp:   return `CP0_EXC_BP;
            excRi:   return `CP0_EXC_RI;
            excCpu:  return `CP0_EXC_CPU;
            excOv:   return `CP0_EXC_OV;
            excTr:   return `CP0_EXC_TR;
            default: return `CP0_EXC_INT;
        endcase
    endfunction

    // Returns the read word before the edge, then moves the shadows past it
    function automatic logic [31:0] refModel(input regAccess_t acc, input excReq_t exc,
                                             input logic [5:0] intrIn);
        logic [31:0] readWord;
        logic        hit;
        logic        enter;
        case (acc.addr)
            `CP0_REG_BADVADDR: readWord = shBad;
            `CP0_REG_COUNT:    readWord = shCount;
            `CP0_REG_COMPARE:  readWord = shCompare;
            `CP0_REG_STATUS:   readWord = shStatus;
            `CP0_REG_CAUSE:    readWord = shCause;
            `CP0_REG_EPC:      readWord = shEpc;
            `CP0_REG_PRID:     readWord = 32'h00004220;
            default:           readWord = 32'd0;
        endcase
        hit     = (shCompare != 32'd0) && (shCount == shCompare);
        enter   = exc.valid && exc.kind != excEret && exc.kind != excNone;
        shCount = shCount + 32'd1;
        if (hit) begin
            shTimer = 1'b1;
        end
        if (exc.valid && exc.kind == excEret) begin
            shStatus[1] = 1'b0;
        end else if (enter) begin
            // EPC and BD hold the first fault while EXL is set
            if (!shStatus[1]) begin
                shEpc       = exc.inSlot ? exc.pc - 32'd4 : exc.pc;
                shCause[31] = exc.inSlot;
            end
            shStatus[1]  = 1'b1;
            shCause[6:2] = excCodeOf(exc.kind);
            if (exc.kind == excCpu) begin
                shCause[29:28] = exc.cpNum;
            end
            if (exc.kind inside {excAdel, excAdes}) begin
                shBad = exc.badAddr;
            end
        end else if (!exc.valid && acc.wen) begin
            case (acc.addr)
                `CP0_REG_STATUS:
                    shStatus = (shStatus & ~STATUS_MASK) | (acc.wdata & STATUS_MASK);
                `CP0_REG_CAUSE:
                    shCause = (shCause & ~CAUSE_MASK) | (acc.wdata & CAUSE_MASK);
                `CP0_REG_EPC:      shEpc = acc.wdata;
                `CP0_REG_BADVADDR: shBad = acc.wdata;
                `CP0_REG_COUNT:    shCount = acc.wdata;
                `CP0_REG_COMPARE: begin
                    shCompare = acc.wdata;
                    shTimer   = 1'b0;
                end
                default: begin
                end
            endcase
        end
        shCause[15:10] = intrIn;
        return readWord;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Error %s: %s expected %h actual %h", testName, what, expected, actual);
            errCount++;
        end
    endtask

    // Drive one cycle at the falling edge and hold it until the next one
    task automatic step(input regAccess_t acc, input excReq_t exc);
        access    = acc;
        excIn     = exc;
        intr      = intrNext;
        expStatus = shStatus;
        expCause  = shCause;
        expEpc    = shEpc;
        expUser   = shStatus[4] & ~(shStatus[2] | shStatus[1]);
        expTimer  = shTimer;
        expRead   = refModel(acc, exc, intrNext);
        @(negedge clk);
    endtask

    task automatic readReg(input logic [4:0] addr);
        step('{addr: addr, wen: 1'b0, wdata: 32'd0}, '0);
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        step('{addr: addr, wen: 1'b1, wdata: data}, '0);
    endtask

    // Optional Compare write in the same cycle, which the exception must swallow
    task automatic raiseExc(input excType_e kind, input logic withWrite);
        excReq_t     exc;
        regAccess_t  acc;
        logic [31:0] r;
        exc         = '0;
        exc.valid   = 1'b1;
        exc.kind    = kind;
        exc.pc      = randBits(32);
        exc.badAddr = randBits(32);
        r           = randBits(3);
        exc.cpNum   = r[1:0];
        exc.inSlot  = r[2];
        acc         = '0;
        if (withWrite) begin
            acc = '{addr: `CP0_REG_COMPARE, wen: 1'b1, wdata: randBits(32)};
        end
        step(acc, exc);
    endtask

    task automatic startTest(input string name);
        testName   = name;
        errAtStart = errCount;
    endtask

    task automatic finishTest();
        if (errCount == errAtStart) begin
            passCount++;
            $display("%s: passed", testName);
        end else begin
            failCount++;
            $display("%s: failed with %0d errors", testName, errCount - errAtStart);
        end
    endtask

    // Outputs have settled 2 ns after the falling edge
    always begin
        @(negedge clk);
        #2;
        if (checkEn) begin
            checkValue("read word", expRead, rdata);
            checkValue("Status", expStatus, 32'(status));
            checkValue("Cause", expCause, 32'(cause));
            checkValue("EPC", expEpc, epc);
            checkValue("usermode", 32'(expUser), 32'(usermode));
            checkValue("timer interrupt", 32'(expTimer), 32'(timerInt));
        end
    end

    initial begin
        logic [31:0] r;
        logic [4:0]  addr;
        int          waited;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst       = 1'b0;
        shStatus  = 32'h00400004;
        shCause   = '0;
        shEpc     = '0;
        shBad     = '0;
        shCount   = '0;
        shCompare = '0;
        shTimer   = 1'b0;
        checkEn   = 1'b1;

        startTest("reset values");
        for (int a = 0; a < 32; a++) begin
            readReg(5'(a));
        end
        finishTest();

        startTest("write readback");
        for (int i = 0; i < 150; i++) begin
            r = randBits(3);
            case (r[2:0])
                3'd0: addr = `CP0_REG_STATUS;
                3'd1: addr = `CP0_REG_CAUSE;
                3'd2: addr = `CP0_REG_EPC;
                3'd3: addr = `CP0_REG_BADVADDR;
                3'd4: addr = `CP0_REG_COMPARE;
                default: addr = 5'd20;
            endcase
            writeReg(addr, randBits(32));
            readReg(addr);
        end
        finishTest();

        startTest("exceptions");
        repeat (3) begin
            for (int k = 1; k <= 9; k++) begin
                writeReg(`CP0_REG_STATUS, 32'h0000FF10);
                raiseExc(excType_e'(k), 1'b1);
                readReg(`CP0_REG_COMPARE);
                readReg(`CP0_REG_EPC);
                readReg(`CP0_REG_CAUSE);
                raiseExc(excSys, 1'b0);
                readReg(`CP0_REG_EPC);
                raiseExc(excEret, 1'b0);
                readReg(`CP0_REG_STATUS);
            end
        end
        finishTest();

        startTest("BadVAddr and CE");
        for (int i = 0; i < 60; i++) begin
            r = randBits(2);
            raiseExc(r[1] ? excCpu : (r[0] ? excAdes : excAdel), 1'b0);
            readReg(`CP0_REG_BADVADDR);
            readReg(`CP0_REG_CAUSE);
            raiseExc(excEret, 1'b0);
        end
        finishTest();

        startTest("timer");
        for (int i = 0; i < 8; i++) begin
            writeReg(`CP0_REG_COUNT, randBits(31));
            r = randBits(4);
            repeat (r + 1) readReg(`CP0_REG_COUNT);
            // Match lands 20 counts past the value seen at this edge
            writeReg(`CP0_REG_COMPARE, shCount + 32'd20);
            waited = 0;
            while (!timerInt && waited < 40) begin
                readReg(`CP0_REG_COMPARE);
                waited++;
            end
            assert (timerInt)
            else begin
                $display("%s: timer interrupt did not rise within 40 cycles", testName);
                errCount++;
            end
            writeReg(`CP0_REG_COMPARE, 32'd0);
            readReg(`CP0_REG_COUNT);
        end
        finishTest();

        startTest("interrupts and usermode");
        for (int i = 0; i < 100; i++) begin
            r        = randBits(6);
            intrNext = r[5:0];
            readReg(`CP0_REG_CAUSE);
            writeReg(`CP0_REG_STATUS, randBits(32));
            if (i % 10 == 0) begin
                raiseExc(excInt, 1'b0);
                raiseExc(excEret, 1'b0);
            end
        end
        finishTest();

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
